// File: Makefile
VERILATOR ?= verilator
TOP       ?= rv64_backend_tb
FLIST     ?= rv64_backend.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/rv64_backend_props.sv
////////////////////////////////////////////////////////////////////////////
// bound into rv64_backend_top; checks are off while reset is low
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module rv64_backend_props (
    input logic                         clk,
    input logic                         rst_n_i,
    input rv64_backend_pkg::stall_vec_t stall_vec_i,
    input rv64_backend_pkg::mem_wb_t    commit_i,
    input logic                         halted_i,
    input logic                         ex_hold_i,
    input logic                         mem_busy_i
);

    // run, memory wait or halted, nothing else
    hold_shape: assert property (@(posedge clk) disable iff (!rst_n_i)
        (stall_vec_i == 5'b00000) || (stall_vec_i == 5'b01111) || (stall_vec_i == 5'b11111))
        else $error("hold vector has illegal value %b", stall_vec_i);

    no_commit_halted: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(commit_i.valid && halted_i))
        else $error("commit while halted at pc %h", commit_i.pc);

    halted_sticky: assert property (@(posedge clk) disable iff (!rst_n_i)
        halted_i |=> halted_i)
        else $error("halted dropped without reset");

    hold_on_busy: assert property (@(posedge clk) disable iff (!rst_n_i)
        mem_busy_i |-> ex_hold_i)
        else $error("memory busy without ex hold");

endmodule

bind rv64_backend_top rv64_backend_props i_props (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .stall_vec_i (stall_vec),
    .commit_i    (commit_o),
    .halted_i    (halted_o),
    .ex_hold_i   (ex_hold_o),
    .mem_busy_i  (mem_busy)
);

// File: dv/rv64_backend_tb.sv
////////////////////////////////////////////////////////////////////////////
// stands in for IF to EX; memory rows share the doubleword at address 0x40
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "rv64_backend_config.svh"

module rv64_backend_tb;

    localparam int TIMEOUT_CYCLES = 100;

    typedef struct packed {
        rv64_backend_pkg::pc_t       pc;
        rv64_backend_pkg::inst_t     inst;
        rv64_backend_pkg::mem_op_t   mem_op;
        rv64_backend_pkg::reg_addr_t rd_addr;
        logic                        rd_ena;
        rv64_backend_pkg::xlen_t     result;
        rv64_backend_pkg::xlen_t     store_data;
        rv64_backend_pkg::xlen_t     exp_data;
    } row_t;

    logic                        clk;
    logic                        rst_n_i;
    rv64_backend_pkg::ex_mem_t   ex_i;
    logic                        ex_hold_o;
    rv64_backend_pkg::reg_addr_t rs_addr_i;
    rv64_backend_pkg::xlen_t     rs_data_o;
    rv64_backend_pkg::mem_wb_t   commit_o;
    logic                        halted_o;
    rv64_backend_pkg::xlen_t     trap_code_o;

    row_t                    rows[$];
    row_t                    exp_q[$];
    row_t                    exp_row;
    rv64_backend_pkg::xlen_t reg_model[32];
    int                      err_cnt;
    int                      commit_cnt;
    logic                    aborted;

    rv64_backend_top i_dut (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .ex_i        (ex_i),
        .ex_hold_o   (ex_hold_o),
        .rs_addr_i   (rs_addr_i),
        .rs_data_o   (rs_data_o),
        .commit_o    (commit_o),
        .halted_o    (halted_o),
        .trap_code_o (trap_code_o)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic report_mismatch(input string name, input rv64_backend_pkg::xlen_t got,
                                   input rv64_backend_pkg::xlen_t exp);
        err_cnt++;
        $display("error: %s is %h, expected %h", name, got, exp);
    endtask

    task automatic report_timeout(input string what);
        err_cnt++;
        aborted = 1'b1;
        $display("timed out after %0d cycles waiting for %s", TIMEOUT_CYCLES, what);
    endtask

    task automatic add_row(input rv64_backend_pkg::inst_t inst, input rv64_backend_pkg::mem_op_t op,
                           input rv64_backend_pkg::reg_addr_t rd, input logic ena,
                           input rv64_backend_pkg::xlen_t result, input rv64_backend_pkg::xlen_t sdata,
                           input rv64_backend_pkg::xlen_t exp);
        row_t r;
        r.pc         = 64'h8000_0000 + 64'(rows.size() * 4);
        r.inst       = inst;
        r.mem_op     = op;
        r.rd_addr    = rd;
        r.rd_ena     = ena;
        r.result     = result;
        r.store_data = sdata;
        r.exp_data   = exp;
        rows.push_back(r);
        exp_q.push_back(r);
        if (ena && (rd != 5'd0)) begin
            reg_model[rd] = exp;
        end
    endtask

    task automatic build_table();
        for (int i = 0; i < 32; i++) begin
            reg_model[i] = '0;
        end
        // the second alu row targets x0
        add_row(32'h0010_0093, `RV_MOP_NONE, 5'd1, 1'b1, 64'h1111_2222_3333_4444, '0,
                64'h1111_2222_3333_4444);
        add_row(32'h0120_0013, `RV_MOP_NONE, 5'd0, 1'b1, 64'h0000_0000_0000_dead, '0,
                64'h0000_0000_0000_dead);
        add_row(32'h8000_0137, `RV_MOP_NONE, 5'd2, 1'b1, 64'h8000_0000_0000_0001, '0,
                64'h8000_0000_0000_0001);
        // stores leave bytes 3c dc ba 98 87 65 a5 ef from msb down
        add_row(32'h0420_3023, `RV_MOP_SD, 5'd0, 1'b0, 64'h40, 64'h0123_4567_89ab_cdef, 64'h40);
        add_row(32'h0420_2223, `RV_MOP_SW, 5'd0, 1'b0, 64'h44, 64'h5555_5555_fedc_ba98, 64'h44);
        add_row(32'h0420_1123, `RV_MOP_SH, 5'd0, 1'b0, 64'h42, 64'hffff_ffff_ffff_8765, 64'h42);
        add_row(32'h0420_00a3, `RV_MOP_SB, 5'd0, 1'b0, 64'h41, 64'h0000_0000_1234_56a5, 64'h41);
        add_row(32'h0420_03a3, `RV_MOP_SB, 5'd0, 1'b0, 64'h47, 64'h0000_0000_0000_003c, 64'h47);
        // loads of every width and sign
        add_row(32'h0400_3183, `RV_MOP_LD,  5'd3,  1'b1, 64'h40, '0, 64'h3cdc_ba98_8765_a5ef);
        add_row(32'h0410_0203, `RV_MOP_LB,  5'd4,  1'b1, 64'h41, '0, 64'hffff_ffff_ffff_ffa5);
        add_row(32'h0410_4283, `RV_MOP_LBU, 5'd5,  1'b1, 64'h41, '0, 64'h0000_0000_0000_00a5);
        add_row(32'h0420_1303, `RV_MOP_LH,  5'd6,  1'b1, 64'h42, '0, 64'hffff_ffff_ffff_8765);
        add_row(32'h0420_5383, `RV_MOP_LHU, 5'd7,  1'b1, 64'h42, '0, 64'h0000_0000_0000_8765);
        add_row(32'h0400_2403, `RV_MOP_LW,  5'd8,  1'b1, 64'h40, '0, 64'hffff_ffff_8765_a5ef);
        add_row(32'h0440_6483, `RV_MOP_LWU, 5'd9,  1'b1, 64'h44, '0, 64'h0000_0000_3cdc_ba98);
        add_row(32'h0470_0583, `RV_MOP_LB,  5'd11, 1'b1, 64'h47, '0, 64'h0000_0000_0000_003c);
        add_row(32'h0440_2603, `RV_MOP_LW,  5'd12, 1'b1, 64'h44, '0, 64'h0000_0000_3cdc_ba98);
        add_row(32'h0400_6703, `RV_MOP_LWU, 5'd14, 1'b1, 64'h40, '0, 64'h0000_0000_8765_a5ef);
        // trap code into x10 before the ebreak
        add_row(32'h0420_0513, `RV_MOP_NONE, 5'd10, 1'b1, 64'h0000_0000_c0de_0042, '0,
                64'h0000_0000_c0de_0042);
        add_row(`RV_EBREAK, `RV_MOP_NONE, 5'd0, 1'b0, '0, '0, '0);
    endtask

    task automatic sweep_registers(input string when);
        for (int i = 0; i < 32; i++) begin
            @(posedge clk);
            rs_addr_i <= 5'(i);
            @(negedge clk);
            if (rs_data_o !== reg_model[i]) begin
                report_mismatch($sformatf("rs_data_o (x%0d, %s)", i, when),
                                rs_data_o, reg_model[i]);
            end
        end
    endtask

    task automatic issue_row(input row_t r);
        rv64_backend_pkg::ex_mem_t e;
        int                        gap;
        int                        waited;
        logic                      accepted;
        e            = '0;
        e.valid      = 1'b1;
        e.pc         = r.pc;
        e.inst       = r.inst;
        e.mem_op     = r.mem_op;
        e.rd_addr    = r.rd_addr;
        e.rd_ena     = r.rd_ena;
        e.result     = r.result;
        e.store_data = r.store_data;
        gap          = int'($urandom % 4);
        repeat (gap) @(posedge clk);
        @(posedge clk);
        ex_i <= e;
        accepted = 1'b0;
        waited   = 0;
        while (!accepted && !aborted) begin
            @(negedge clk);
            if (!ex_hold_o) begin
                accepted = 1'b1;
            end else begin
                waited++;
                if (waited > TIMEOUT_CYCLES) begin
                    report_timeout("ex_hold_o to drop");
                end
            end
        end
        if (!aborted) begin
            @(posedge clk);
            ex_i <= '0;
            // busy shows in the cycle after the capture
            if (r.mem_op != `RV_MOP_NONE) begin
                @(negedge clk);
                if (ex_hold_o !== 1'b1) begin
                    report_mismatch($sformatf("ex_hold_o (memory access at pc %h)", r.pc),
                                    64'(ex_hold_o), 64'h1);
                end
            end
        end
    endtask

    task automatic offer_after_halt();
        rv64_backend_pkg::ex_mem_t e;
        int                        waited;
        e         = '0;
        e.valid   = 1'b1;
        e.pc      = 64'h8000_0000 + 64'(rows.size() * 4);
        e.inst    = 32'h0550_0693;
        e.rd_addr = 5'd13;
        e.rd_ena  = 1'b1;
        e.result  = 64'h0000_0000_0000_5555;
        @(posedge clk);
        ex_i <= e;
        waited = 0;
        while (!halted_o && !aborted) begin
            @(negedge clk);
            waited++;
            if (!halted_o && (waited > TIMEOUT_CYCLES)) begin
                report_timeout("halted_o after the ebreak");
            end
        end
        if (!aborted) begin
            // the late row must never commit in this window
            repeat (20) begin
                @(negedge clk);
                if (ex_hold_o !== 1'b1) begin
                    report_mismatch("ex_hold_o (after halt)", 64'(ex_hold_o), 64'h1);
                end
                if (halted_o !== 1'b1) begin
                    report_mismatch("halted_o (after halt)", 64'(halted_o), 64'h1);
                end
            end
            if (trap_code_o !== reg_model[10]) begin
                report_mismatch("trap_code_o", trap_code_o, reg_model[10]);
            end
        end
    endtask

    // expected records pop in table order
    always @(negedge clk) begin
        if (rst_n_i && commit_o.valid) begin
            if (exp_q.size() == 0) begin
                err_cnt++;
                $display("commit at pc %h with no instruction left to commit", commit_o.pc);
            end else begin
                exp_row = exp_q.pop_front();
                commit_cnt++;
                if (commit_o.pc !== exp_row.pc) begin
                    report_mismatch("commit_o.pc", commit_o.pc, exp_row.pc);
                end
                if (commit_o.inst !== exp_row.inst) begin
                    report_mismatch("commit_o.inst", 64'(commit_o.inst), 64'(exp_row.inst));
                end
                if (commit_o.rd_addr !== exp_row.rd_addr) begin
                    report_mismatch("commit_o.rd_addr", 64'(commit_o.rd_addr),
                                    64'(exp_row.rd_addr));
                end
                if (commit_o.rd_ena !== exp_row.rd_ena) begin
                    report_mismatch("commit_o.rd_ena", 64'(commit_o.rd_ena),
                                    64'(exp_row.rd_ena));
                end
                if (commit_o.rd_data !== exp_row.exp_data) begin
                    report_mismatch("commit_o.rd_data", commit_o.rd_data, exp_row.exp_data);
                end
            end
        end
    end

    initial begin
        void'($urandom(12076));
        err_cnt    = 0;
        commit_cnt = 0;
        aborted    = 1'b0;
        rst_n_i    = 1'b0;
        ex_i       = '0;
        rs_addr_i  = '0;
        build_table();
        repeat (10) @(posedge clk);
        rst_n_i <= 1'b1;
        @(negedge clk);
        if (ex_hold_o !== 1'b0) begin
            report_mismatch("ex_hold_o (after reset)", 64'(ex_hold_o), 64'h0);
        end
        if (halted_o !== 1'b0) begin
            report_mismatch("halted_o (after reset)", 64'(halted_o), 64'h0);
        end
        if (commit_o.valid !== 1'b0) begin
            report_mismatch("commit_o.valid (after reset)", 64'(commit_o.valid), 64'h0);
        end
        begin : reset_sweep
            rv64_backend_pkg::xlen_t saved[32];
            for (int i = 0; i < 32; i++) begin
                saved[i]     = reg_model[i];
                reg_model[i] = '0;
            end
            sweep_registers("after reset");
            for (int i = 0; i < 32; i++) begin
                reg_model[i] = saved[i];
            end
        end
        for (int i = 0; (i < rows.size()) && !aborted; i++) begin
            issue_row(rows[i]);
        end
        if (!aborted) begin
            offer_after_halt();
        end
        if (!aborted) begin
            sweep_registers("after halt");
        end
        if (exp_q.size() != 0) begin
            err_cnt++;
            $display("%0d expected commits never arrived", exp_q.size());
        end
        $display("errors: %0d, commits: %0d of %0d", err_cnt, commit_cnt, rows.size());
        if (err_cnt == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: rv64_backend.f
+incdir+verilog
verilog/rv64_backend_pkg.sv
verilog/stall_ctrl.sv
verilog/mem_stage.sv
verilog/mem_wb.sv
verilog/regfile.sv
verilog/commit_trap.sv
verilog/rv64_backend_top.sv
dv/rv64_backend_props.sv
dv/rv64_backend_tb.sv

// File: verilog/commit_trap.sv
////////////////////////////////////////////////////////////////////////////
// first committed EBREAK ends all commits; trap code held until reset
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "rv64_backend_config.svh"

module commit_trap (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  rv64_backend_pkg::mem_wb_t wb_i,
    input  rv64_backend_pkg::xlen_t   a0_data_i,
    output rv64_backend_pkg::mem_wb_t commit_o,
    output logic                      trap_hit_o,
    output rv64_backend_pkg::xlen_t   trap_code_o
);

    rv64_backend_pkg::mem_wb_t rec_q;
    logic                      commit_valid_q;
    logic                      trap_done_q;

    // one pulse, WB keeps the ebreak afterwards
    assign trap_hit_o = wb_i.valid && (wb_i.inst == `RV_EBREAK) && !trap_done_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            commit_valid_q <= 1'b0;
            trap_done_q    <= 1'b0;
            trap_code_o    <= '0;
        end else begin
            commit_valid_q <= wb_i.valid && !trap_done_q;
            if (trap_hit_o) begin
                trap_done_q <= 1'b1;
                trap_code_o <= a0_data_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        rec_q <= wb_i;
    end

    always_comb begin
        commit_o       = rec_q;
        commit_o.valid = commit_valid_q;
    end

endmodule

// File: verilog/mem_stage.sv
////////////////////////////////////////////////////////////////////////////
// aligned accesses only; low address bits pick the lane, they never fault
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "rv64_backend_config.svh"

module mem_stage (
    input  logic                         clk,
    input  logic                         rst_n_i,
    input  rv64_backend_pkg::ex_mem_t    ex_i,
    input  rv64_backend_pkg::stall_vec_t stall_i,
    output logic                         mem_busy_o,
    output rv64_backend_pkg::mem_wb_t    mem_o
);

    localparam int IDX_W = $clog2(`RV_DMEM_DEPTH);
    localparam int CNT_W = $clog2(`RV_DMEM_LAT + 1);

    rv64_backend_pkg::ex_mem_t ex_q;
    logic [CNT_W-1:0]          lat_cnt_q;
    rv64_backend_pkg::xlen_t   dmem [`RV_DMEM_DEPTH];
    logic [IDX_W-1:0]          dmem_idx;
    logic [2:0]                byte_off;
    logic                      is_store;
    logic                      capture;
    logic                      advance;
    logic [7:0]                wr_mask;
    rv64_backend_pkg::xlen_t   wr_data;
    rv64_backend_pkg::xlen_t   rd_word;
    logic [7:0]                ld_byte;
    logic [15:0]               ld_half;
    logic [31:0]               ld_word;
    rv64_backend_pkg::xlen_t   ld_data;

    assign dmem_idx   = ex_q.result[IDX_W+2:3];
    assign byte_off   = ex_q.result[2:0];
    assign is_store   = ex_q.mem_op inside {`RV_MOP_SB, `RV_MOP_SH, `RV_MOP_SW, `RV_MOP_SD};
    // busy until the counter reaches the latency
    assign mem_busy_o = ex_q.valid && (ex_q.mem_op != `RV_MOP_NONE)
                        && (lat_cnt_q != CNT_W'(`RV_DMEM_LAT));
    assign capture    = !stall_i[`RV_STG_EX] && !mem_busy_o;
    // a halted pipe freezes the counter too
    assign advance    = mem_busy_o && !stall_i[`RV_STG_WB];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ex_q      <= '0;
            lat_cnt_q <= '0;
        end else if (capture) begin
            ex_q      <= ex_i;
            lat_cnt_q <= '0;
        end else if (advance) begin
            lat_cnt_q <= lat_cnt_q + 1'b1;
        end
    end

    // store lanes, data replicated so the mask alone picks the bytes
    always_comb begin
        wr_mask = 8'h00;
        wr_data = ex_q.store_data;
        case (ex_q.mem_op)
            `RV_MOP_SB: begin
                wr_mask = 8'h01 << byte_off;
                wr_data = {8{ex_q.store_data[7:0]}};
            end
            `RV_MOP_SH: begin
                wr_mask = 8'h03 << {byte_off[2:1], 1'b0};
                wr_data = {4{ex_q.store_data[15:0]}};
            end
            `RV_MOP_SW: begin
                wr_mask = 8'h0f << {byte_off[2], 2'b00};
                wr_data = {2{ex_q.store_data[31:0]}};
            end
            `RV_MOP_SD: wr_mask = 8'hff;
            default: wr_mask = 8'h00;
        endcase
    end

    // write once, on the last busy cycle
    always_ff @(posedge clk) begin
        if (advance && is_store && (lat_cnt_q == CNT_W'(`RV_DMEM_LAT - 1))) begin
            for (int i = 0; i < 8; i++) begin
                if (wr_mask[i]) begin
                    dmem[dmem_idx][8*i +: 8] <= wr_data[8*i +: 8];
                end
            end
        end
    end

    assign rd_word = dmem[dmem_idx];
    assign ld_byte = rd_word[8*byte_off +: 8];
    assign ld_half = rd_word[16*byte_off[2:1] +: 16];
    assign ld_word = rd_word[32*byte_off[2] +: 32];

    always_comb begin
        case (ex_q.mem_op)
            `RV_MOP_LB:  ld_data = {{(`RV_XLEN-8){ld_byte[7]}}, ld_byte};
            `RV_MOP_LH:  ld_data = {{(`RV_XLEN-16){ld_half[15]}}, ld_half};
            `RV_MOP_LW:  ld_data = {{(`RV_XLEN-32){ld_word[31]}}, ld_word};
            `RV_MOP_LD:  ld_data = rd_word;
            `RV_MOP_LBU: ld_data = {{(`RV_XLEN-8){1'b0}}, ld_byte};
            `RV_MOP_LHU: ld_data = {{(`RV_XLEN-16){1'b0}}, ld_half};
            `RV_MOP_LWU: ld_data = {{(`RV_XLEN-32){1'b0}}, ld_word};
            // alu ops and stores carry the result through
            default:     ld_data = ex_q.result;
        endcase
    end

    always_comb begin
        mem_o.valid   = ex_q.valid;
        mem_o.pc      = ex_q.pc;
        mem_o.inst    = ex_q.inst;
        mem_o.rd_addr = ex_q.rd_addr;
        mem_o.rd_ena  = ex_q.rd_ena;
        mem_o.rd_data = ld_data;
    end

endmodule

// File: verilog/mem_wb.sv
////////////////////////////////////////////////////////////////////////////
// WB hold wins over MEM hold; a MEM hold alone inserts a bubble
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "rv64_backend_config.svh"

module mem_wb (
    input  logic                         clk,
    input  logic                         rst_n_i,
    input  rv64_backend_pkg::stall_vec_t stall_i,
    input  rv64_backend_pkg::mem_wb_t    mem_i,
    output rv64_backend_pkg::mem_wb_t    wb_o
);

    rv64_backend_pkg::mem_wb_t wb_d;
    logic                      hold_wb;
    logic                      hold_mem;

    assign hold_wb  = stall_i[`RV_STG_WB];
    assign hold_mem = stall_i[`RV_STG_MEM];

    always_comb begin
        if (hold_wb) begin
            // halted pipe keeps the last record
            wb_d = wb_o;
        end else if (hold_mem) begin
            // bubble while memory is busy
            wb_d = '0;
        end else begin
            wb_d = mem_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wb_o <= '0;
        end else begin
            wb_o <= wb_d;
        end
    end

endmodule

// File: verilog/regfile.sv
////////////////////////////////////////////////////////////////////////////
// reads are combinational and return the old value during a write
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "rv64_backend_config.svh"

module regfile (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  rv64_backend_pkg::mem_wb_t   wb_i,
    input  rv64_backend_pkg::reg_addr_t rs_addr_i,
    output rv64_backend_pkg::xlen_t     rs_data_o,
    output rv64_backend_pkg::xlen_t     a0_data_o
);

    localparam int NREGS = 1 << `RV_REG_ADDR_W;
    localparam rv64_backend_pkg::reg_addr_t A0_ADDR = 5'd10;

    rv64_backend_pkg::xlen_t regs_q [NREGS];
    logic                    wr_en;

    // x0 is never written
    assign wr_en = wb_i.valid && wb_i.rd_ena && (wb_i.rd_addr != '0);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NREGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en) begin
            regs_q[wb_i.rd_addr] <= wb_i.rd_data;
        end
    end

    assign rs_data_o = (rs_addr_i == '0) ? '0 : regs_q[rs_addr_i];
    // trap code source
    assign a0_data_o = regs_q[A0_ADDR];

endmodule

// File: verilog/rv64_backend_config.svh
////////////////////////////////////////////////////////////////////////////
// back end parameters; DMEM_LAT must be 1 or more, DMEM_DEPTH a power of 2
// mem-op codes 8 and up are stores, 1 to 7 are loads
////////////////////////////////////////////////////////////////////////////
`ifndef RV64_BACKEND_CONFIG_SVH
`define RV64_BACKEND_CONFIG_SVH

`define RV_XLEN         64
`define RV_REG_ADDR_W   5
`define RV_DMEM_DEPTH   256
`define RV_DMEM_LAT     3

// bit positions in the hold vector
`define RV_STG_EX       2
`define RV_STG_MEM      3
`define RV_STG_WB       4

`define RV_MOP_NONE     4'd0
`define RV_MOP_LB       4'd1
`define RV_MOP_LH       4'd2
`define RV_MOP_LW       4'd3
`define RV_MOP_LD       4'd4
`define RV_MOP_LBU      4'd5
`define RV_MOP_LHU      4'd6
`define RV_MOP_LWU      4'd7
`define RV_MOP_SB       4'd8
`define RV_MOP_SH       4'd9
`define RV_MOP_SW       4'd10
`define RV_MOP_SD       4'd11

`define RV_EBREAK       32'h0010_0073

`endif

// File: verilog/rv64_backend_pkg.sv
////////////////////////////////////////////////////////////////////////////
// shared types for the back end; widths come from the config header
////////////////////////////////////////////////////////////////////////////
`include "rv64_backend_config.svh"

package rv64_backend_pkg;

    typedef logic [`RV_XLEN-1:0]       xlen_t;
    typedef logic [63:0]               pc_t;
    typedef logic [31:0]               inst_t;
    typedef logic [`RV_REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [3:0]                mem_op_t;
    // bit n set holds stage n, bit 0 is IF
    typedef logic [4:0]                stall_vec_t;

    // executed instruction entering the memory stage
    typedef struct packed {
        logic      valid;
        pc_t       pc;
        inst_t     inst;
        mem_op_t   mem_op;
        reg_addr_t rd_addr;
        logic      rd_ena;
        xlen_t     result;
        xlen_t     store_data;
    } ex_mem_t;

    // write back and commit record
    typedef struct packed {
        logic      valid;
        pc_t       pc;
        inst_t     inst;
        reg_addr_t rd_addr;
        logic      rd_ena;
        xlen_t     rd_data;
    } mem_wb_t;

    typedef enum logic [1:0] {
        RUN,
        MEM_WAIT,
        HALTED
    } ctrl_state_e;

endpackage

// File: verilog/rv64_backend_top.sv
////////////////////////////////////////////////////////////////////////////
// ex_i must stay stable while ex_hold_o is high; no forwarding inside
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "rv64_backend_config.svh"

module rv64_backend_top (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  rv64_backend_pkg::ex_mem_t   ex_i,
    output logic                        ex_hold_o,
    input  rv64_backend_pkg::reg_addr_t rs_addr_i,
    output rv64_backend_pkg::xlen_t     rs_data_o,
    output rv64_backend_pkg::mem_wb_t   commit_o,
    output logic                        halted_o,
    output rv64_backend_pkg::xlen_t     trap_code_o
);

    rv64_backend_pkg::stall_vec_t stall_vec;
    rv64_backend_pkg::mem_wb_t    mem_rec;
    rv64_backend_pkg::mem_wb_t    wb_rec;
    rv64_backend_pkg::xlen_t      a0_data;
    logic                         mem_busy;
    logic                         trap_hit;

    assign ex_hold_o = stall_vec[`RV_STG_EX];

    stall_ctrl i_stall_ctrl (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .mem_busy_i (mem_busy),
        .trap_hit_i (trap_hit),
        .stall_o    (stall_vec),
        .halted_o   (halted_o)
    );

    mem_stage i_mem_stage (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .ex_i       (ex_i),
        .stall_i    (stall_vec),
        .mem_busy_o (mem_busy),
        .mem_o      (mem_rec)
    );

    mem_wb i_mem_wb (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .stall_i (stall_vec),
        .mem_i   (mem_rec),
        .wb_o    (wb_rec)
    );

    regfile i_regfile (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .wb_i      (wb_rec),
        .rs_addr_i (rs_addr_i),
        .rs_data_o (rs_data_o),
        .a0_data_o (a0_data)
    );

    commit_trap i_commit_trap (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .wb_i        (wb_rec),
        .a0_data_i   (a0_data),
        .commit_o    (commit_o),
        .trap_hit_o  (trap_hit),
        .trap_code_o (trap_code_o)
    );

endmodule

// File: verilog/stall_ctrl.sv
////////////////////////////////////////////////////////////////////////////
// hold vector follows mem busy in the same cycle; HALTED is left only by reset
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module stall_ctrl (
    input  logic                         clk,
    input  logic                         rst_n_i,
    input  logic                         mem_busy_i,
    input  logic                         trap_hit_i,
    output rv64_backend_pkg::stall_vec_t stall_o,
    output logic                         halted_o
);

    localparam rv64_backend_pkg::stall_vec_t HOLD_NONE  = 5'b00000;
    localparam rv64_backend_pkg::stall_vec_t HOLD_FRONT = 5'b01111;
    localparam rv64_backend_pkg::stall_vec_t HOLD_ALL   = 5'b11111;

    rv64_backend_pkg::ctrl_state_e state_q;
    rv64_backend_pkg::ctrl_state_e state_d;

    always_comb begin
        state_d = state_q;
        stall_o = HOLD_NONE;
        case (state_q)
            rv64_backend_pkg::RUN,
            rv64_backend_pkg::MEM_WAIT: begin
                if (trap_hit_i) begin
                    // freeze everything while the ebreak commits
                    state_d = rv64_backend_pkg::HALTED;
                    stall_o = HOLD_ALL;
                end else if (mem_busy_i) begin
                    state_d = rv64_backend_pkg::MEM_WAIT;
                    stall_o = HOLD_FRONT;
                end else begin
                    state_d = rv64_backend_pkg::RUN;
                end
            end
            default: begin
                state_d = rv64_backend_pkg::HALTED;
                stall_o = HOLD_ALL;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q  <= rv64_backend_pkg::RUN;
            halted_o <= 1'b0;
        end else begin
            state_q  <= state_d;
            halted_o <= (state_q == rv64_backend_pkg::HALTED);
        end
    end

endmodule
